//--- Bender.yml
package:
  name: gs_download

sources:
  - src/gs_dl_pkg.sv
  - src/gs_dl_capture.sv
  - src/gs_dl_region.sv
  - src/gs_dl_remap.sv
  - src/gs_download.sv
  - target: test
    files:
      - dv/gs_download_assertions.sv
      - dv/gs_download_tb.sv

//--- dv/gs_download_assertions.sv
// ROM download output protocol checks
// Bound to the top level, covers SDRAM hold and PROM pulse rules

`timescale 1ns/100ps

module gs_download_assertions (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              sdram_ack,
    input logic                              prog_we,
    input logic [gs_dl_pkg::prom_count-1:0]  prom_we,
    input logic [gs_dl_pkg::addr_w-1:0]      prog_addr,
    input logic [gs_dl_pkg::data_w-1:0]      prog_data,
    input logic [gs_dl_pkg::mask_w-1:0]      prog_mask
);

    // Number of failed assertions, read by the testbench
    int fails = 0;

    // Write enable drops only on an acknowledge
    a_we_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(prog_we) |-> $past(sdram_ack))
        else begin
            $error("prog_we fell without sdram_ack");
            fails++;
        end

    a_prom_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(prom_we))
        else begin
            $error("prom_we has more than one bit set");
            fails++;
        end

    // Same PROM bit never stays high two cycles
    a_prom_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (prom_we != '0) |=> ((prom_we & $past(prom_we)) == '0))
        else begin
            $error("prom_we bit held longer than one cycle");
            fails++;
        end

    a_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(prog_we && (prom_we != '0)))
        else begin
            $error("prog_we and prom_we high together");
            fails++;
        end

    a_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (prog_we && $past(prog_we)) |-> $stable({prog_addr, prog_data, prog_mask}))
        else begin
            $error("SDRAM write changed while prog_we held");
            fails++;
        end

endmodule

bind gs_download gs_download_assertions gs_download_assertions_inst (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .sdram_ack ( sdram_ack ),
    .prog_we   ( prog_we   ),
    .prom_we   ( prom_we   ),
    .prog_addr ( prog_addr ),
    .prog_data ( prog_data ),
    .prog_mask ( prog_mask )
);

//--- dv/gs_download_stim.txt
# test downloading addr data ack_delay kind(0 none,1 sdram,2 prom)
# exp_addr exp_data exp_mask(binary) prom_index
1 1 000000 11 0 1 000000 11 10 0
1 1 000001 22 0 1 000000 22 01 0
1 1 001235 33 2 1 00091A 33 01 0
1 1 018000 44 1 1 00C000 44 10 0
1 1 01FFFF 55 0 1 00FFFF 55 01 0
1 1 020003 56 0 1 010001 56 01 0
1 1 024002 57 3 1 012001 57 10 0
2 1 02C000 61 0 1 016000 61 10 0
2 1 04C000 62 1 1 016000 62 01 0
2 1 04BFFF 63 0 1 035FFF 63 10 0
2 1 06C010 64 2 1 036010 64 10 0
2 1 08C010 65 0 1 036010 65 01 0
2 1 0ABFFF 66 0 1 055FFF 66 01 0
3 1 0AC000 A0 0 2 000000 A0 00 0
3 1 0AC105 A1 0 2 000005 A1 00 1
3 1 0AC9FF A2 0 2 0000FF A2 00 9
3 1 0AC4FE A3 0 2 0000FE A3 00 4
3 1 0AC810 A4 0 0 000000 00 00 0
3 1 0ACA00 A5 0 0 000000 00 00 0
3 1 3FFFFF A6 0 0 000000 00 00 0
4 0 000010 B0 0 0 000000 00 00 0
4 0 0AC000 B1 0 0 000000 00 00 0
5 1 000100 C0 8 1 000080 C0 10 0
5 1 000101 C1 8 1 000080 C1 01 0
5 1 000102 C2 6 1 000081 C2 10 0
5 1 0AC203 C3 0 2 000003 C3 00 2
5 1 02C005 C4 7 1 016005 C4 10 0
5 1 000103 C5 5 1 000081 C5 01 0

//--- dv/gs_download_tb.sv
// ROM download testbench
// Streams loader bytes from the stim file, answers SDRAM writes after a
// per-byte delay and checks every write against the region map

`timescale 1ns/100ps

module gs_download_tb;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic        ioctl_wr;
    logic [21:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        sdram_ack;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic [9:0]  prom_we;

    int          t_id[64];
    int          t_dl[64];
    logic [21:0] t_addr[64];
    logic [7:0]  t_data[64];
    int          t_delay[64];
    int          t_kind[64];
    logic [21:0] t_eaddr[64];
    logic [7:0]  t_edata[64];
    logic [1:0]  t_emask[64];
    int          t_eidx[64];
    int          n_lines = 0;
    int          errors = 0;
    int          checked = 0;
    int          outstanding = 0;
    int          limit = 0;
    int          cycles = 0;
    int          exp_q[$];
    int          ack_q[$];

    gs_download gs_download_inst (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Testbench checks plus bound assertion failures
    function automatic int error_count();
        return errors + gs_download_inst.gs_download_assertions_inst.fails;
    endfunction

    // Region map written out from the memory map, not from the DUT
    task automatic expect_item(input int dl, input logic [21:0] a, output int kind,
                               output logic [21:0] wa, output logic [1:0] m,
                               output int idx);
        logic [21:0] off;
        kind = 1;
        idx  = 0;
        if (dl == 0 || a >= gs_dl_pkg::prom_end) begin
            kind = 0;
            wa = '0;
            m = '0;
        end else if (a >= gs_dl_pkg::prom_base) begin
            off  = a - gs_dl_pkg::prom_base;
            idx  = off / 256;
            wa   = off % 256;
            m    = '0;
            kind = (idx == 8) ? 0 : 2;
        end else if (a >= gs_dl_pkg::scroll_base) begin
            off = (a >= gs_dl_pkg::obj_base) ? a - gs_dl_pkg::obj_base
                                             : a - gs_dl_pkg::scroll_base;
            wa  = ((a - off) >> 1) + off;
            m   = 2'b10;
            if (off >= 22'h02_0000) begin
                wa = wa - 22'h02_0000;
                m  = 2'b01;
            end
        end else begin
            wa = a >> 1;
            m  = a[0] ? 2'b01 : 2'b10;
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          kind;
        int          idx;
        logic [21:0] wa;
        logic [1:0]  m;
        reg [8*128-1:0] line_buf;
        fd = $fopen("dv/gs_download_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0 &&
                    $sscanf(line_buf, "%d %d %h %h %d %d %h %h %b %d",
                            t_id[n_lines], t_dl[n_lines], t_addr[n_lines],
                            t_data[n_lines], t_delay[n_lines], t_kind[n_lines],
                            t_eaddr[n_lines], t_edata[n_lines], t_emask[n_lines],
                            t_eidx[n_lines]) == 10) begin
                    expect_item(t_dl[n_lines], t_addr[n_lines], kind, wa, m, idx);
                    assert (kind == t_kind[n_lines]) else begin
                        $display("Mismatch stim line %0d kind: file %h model %h",
                                 n_lines, t_kind[n_lines], kind);
                        errors++;
                    end
                    if (kind != 0) begin
                        assert (wa == t_eaddr[n_lines]) else begin
                            $display("Mismatch stim line %0d exp_addr: file %h model %h",
                                     n_lines, t_eaddr[n_lines], wa);
                            errors++;
                        end
                        assert (t_edata[n_lines] == t_data[n_lines]) else begin
                            $display("Mismatch stim line %0d exp_data: file %h model %h",
                                     n_lines, t_edata[n_lines], t_data[n_lines]);
                            errors++;
                        end
                    end
                    if (kind == 1) begin
                        assert (m == t_emask[n_lines]) else begin
                            $display("Mismatch stim line %0d exp_mask: file %h model %h",
                                     n_lines, t_emask[n_lines], m);
                            errors++;
                        end
                    end else if (kind == 2) begin
                        assert (idx == t_eidx[n_lines]) else begin
                            $display("Mismatch stim line %0d prom_index: file %h model %h",
                                     n_lines, t_eidx[n_lines], idx);
                            errors++;
                        end
                    end
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Acknowledge each SDRAM write after its own delay
    initial begin
        int d;
        forever begin
            @(negedge clk);
            if (prog_we && !sdram_ack && ack_q.size() > 0) begin
                d = ack_q.pop_front();
                repeat (d) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
            end
        end
    end

    // Output monitor, compares each write in order
    initial begin
        logic prev_we;
        int   i;
        int   got_idx;
        prev_we = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && ((prog_we && !prev_we) || prom_we != '0)) begin
                got_idx = 0;
                for (int b = 0; b < 10; b++) begin
                    if (prom_we[b]) got_idx = b;
                end
                assert (exp_q.size() > 0) else begin
                    $display("Unexpected write to address %h", prog_addr);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    i = exp_q.pop_front();
                    assert (prog_addr == t_eaddr[i]) else begin
                        $display("Mismatch prog_addr: got %h expected %h", prog_addr, t_eaddr[i]);
                        errors++;
                    end
                    assert (prog_data == t_edata[i]) else begin
                        $display("Mismatch prog_data: got %h expected %h", prog_data, t_edata[i]);
                        errors++;
                    end
                    if (t_kind[i] == 1) begin
                        assert (prog_we && prom_we == '0 && prog_mask == t_emask[i]) else begin
                            $display("Mismatch prog_mask: got %h expected %h",
                                     prog_mask, t_emask[i]);
                            errors++;
                        end
                    end else begin
                        assert (!prog_we && got_idx == t_eidx[i]) else begin
                            $display("Mismatch prom_we: got %h expected index %h",
                                     prom_we, t_eidx[i]);
                            errors++;
                        end
                        outstanding--;
                    end
                    checked++;
                end
            end
            if (!prog_we && prev_we) outstanding--;
            prev_we = prog_we;
        end
    end

    // Run limit from the stim length and the longest acknowledge delay
    initial begin
        forever begin
            @(posedge clk);
            cycles++;
            if (limit > 0 && cycles > limit) begin
                $display("Timeout after %0d cycles with %0d writes missing", cycles,
                         exp_q.size());
                $display("TEST FAIL");
                $finish;
            end
        end
    end

    initial begin
        int maxd;
        int edges;
        int err0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        sdram_ack   = 1'b0;
        load_stim();
        maxd = 0;
        for (int i = 0; i < n_lines; i++) begin
            if (t_delay[i] > maxd) maxd = t_delay[i];
        end
        limit = 4 + n_lines * (3 + maxd + 4);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        assert (!prog_we && prom_we == '0) else begin
            $display("Outputs active after reset");
            errors++;
        end
        for (int i = 0; i < n_lines; i++) begin
            if (i == 0 || t_id[i] != t_id[i-1]) begin
                err0 = error_count();
            end
            if (t_kind[i] == 0) begin
                while (outstanding > 0) @(negedge clk);
            end
            // Four bytes fit in flight, the last one in the capture skid register
            while (outstanding >= 4) @(negedge clk);
            if (t_kind[i] != 0) begin
                exp_q.push_back(i);
                outstanding++;
                if (t_kind[i] == 1) ack_q.push_back(t_delay[i]);
            end
            downloading = (t_dl[i] != 0);
            ioctl_addr  = t_addr[i];
            ioctl_dout  = t_data[i];
            ioctl_wr    = 1'b1;
            @(posedge clk);
            edges = 1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            if (i == 0) begin
                // First byte meets an idle pipeline
                while (!prog_we && prom_we == '0 && edges < 10) begin
                    @(posedge clk);
                    edges++;
                    @(negedge clk);
                end
                assert (edges == 3) else begin
                    $display("First write took %0d clock edges instead of 3", edges);
                    errors++;
                end
            end
            if (t_kind[i] == 0) begin
                repeat (5) @(negedge clk);
            end
            if (i == n_lines - 1 || t_id[i+1] != t_id[i]) begin
                while (outstanding > 0) @(negedge clk);
                repeat (5) @(negedge clk);
                $display("test %0d: %s", t_id[i], (error_count() == err0) ? "ok" : "error");
            end
        end
        $display("%0d writes checked, %0d errors", checked, error_count());
        if (error_count() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- gs_download.f
src/gs_dl_pkg.sv
src/gs_dl_capture.sv
src/gs_dl_region.sv
src/gs_dl_remap.sv
src/gs_download.sv
dv/gs_download_assertions.sv
dv/gs_download_tb.sv

//--- src/gs_dl_capture.sv
// Download capture stage
// Registers loader bytes while downloading, with a one-entry skid buffer
// so a strobe that arrives during a stall is kept

`timescale 1ns/100ps

module gs_dl_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          downloading,
    input  logic                          ioctl_wr,
    input  logic [gs_dl_pkg::addr_w-1:0]  ioctl_addr,
    input  logic [gs_dl_pkg::data_w-1:0]  ioctl_dout,
    input  logic                          stall,
    output logic                          cap_valid,
    output logic [gs_dl_pkg::addr_w-1:0]  cap_addr,
    output logic [gs_dl_pkg::data_w-1:0]  cap_data
);

    logic                          accept;
    logic                          skid_valid;
    logic [gs_dl_pkg::addr_w-1:0]  skid_addr;
    logic [gs_dl_pkg::data_w-1:0]  skid_data;

    assign accept = downloading && ioctl_wr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cap_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (stall) begin
            // Output register is held, an empty one may still be filled
            if (accept && !cap_valid) begin
                cap_valid <= 1'b1;
            end else if (accept) begin
                skid_valid <= 1'b1;
            end
        end else begin
            cap_valid  <= skid_valid || accept;
            skid_valid <= skid_valid && accept;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            if (accept && !cap_valid) begin
                cap_addr <= ioctl_addr;
                cap_data <= ioctl_dout;
            end else if (accept && !skid_valid) begin
                // A third strobe within one stall has nowhere to go
                skid_addr <= ioctl_addr;
                skid_data <= ioctl_dout;
            end
        end else if (skid_valid) begin
            // Older byte leaves first, a new one takes its place
            cap_addr <= skid_addr;
            cap_data <= skid_data;
            if (accept) begin
                skid_addr <= ioctl_addr;
                skid_data <= ioctl_dout;
            end
        end else if (accept) begin
            cap_addr <= ioctl_addr;
            cap_data <= ioctl_dout;
        end
    end

endmodule

//--- src/gs_dl_pkg.sv
// ROM download path shared definitions
// Region map, PROM layout and bus widths for the fixed game memory map

package gs_dl_pkg;

    // Bus widths
    localparam int addr_w = 22;
    localparam int data_w = 8;
    localparam int mask_w = 2;

    typedef enum logic [2:0] {
        reg_main,
        reg_sound,
        reg_char,
        reg_map,
        reg_scroll,
        reg_obj,
        reg_prom,
        reg_none
    } region_e;

    // Region start byte addresses, main starts at 0
    localparam logic [addr_w-1:0] sound_base  = 22'h01_8000;
    localparam logic [addr_w-1:0] char_base   = 22'h02_0000;
    localparam logic [addr_w-1:0] map_base    = 22'h02_4000;
    localparam logic [addr_w-1:0] scroll_base = 22'h02_C000;
    localparam logic [addr_w-1:0] obj_base    = 22'h06_C000;
    localparam logic [addr_w-1:0] prom_base   = 22'h0A_C000;

    // Scroll and object ROMs are split in two halves sharing one word
    localparam logic [addr_w-1:0] gfx_half = 22'h02_0000;

    localparam int prom_size  = 256;
    localparam int prom_count = 10;
    localparam int prom_idx_w = $clog2(prom_count);

    localparam logic [addr_w-1:0] prom_end = prom_base + addr_w'(prom_count * prom_size);

    // Bit position of each PROM in prom_we
    typedef enum logic [prom_idx_w-1:0] {
        prom_red    = 4'd0,
        prom_green  = 4'd1,
        prom_blue   = 4'd2,
        prom_char   = 4'd3,
        prom_scr_lo = 4'd4,
        prom_scr_hi = 4'd5,
        prom_obj_lo = 4'd6,
        prom_obj_hi = 4'd7,
        prom_spare  = 4'd8,
        prom_prior  = 4'd9
    } prom_e;

    function automatic logic [addr_w-1:0] region_base(region_e region);
        case (region)
            reg_sound:  return sound_base;
            reg_char:   return char_base;
            reg_map:    return map_base;
            reg_scroll: return scroll_base;
            reg_obj:    return obj_base;
            reg_prom:   return prom_base;
            default:    return '0;
        endcase
    endfunction

endpackage

//--- src/gs_dl_region.sv
// Download region decode stage
// Classifies each captured byte by ROM region and registers its offset
// from the start of that region. Bytes past the last PROM are dropped

`timescale 1ns/100ps

module gs_dl_region (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cap_valid,
    input  logic [gs_dl_pkg::addr_w-1:0]  cap_addr,
    input  logic [gs_dl_pkg::data_w-1:0]  cap_data,
    input  logic                          stall,
    output logic                          reg_valid,
    output gs_dl_pkg::region_e            reg_region,
    output logic [gs_dl_pkg::addr_w-1:0]  reg_offset,
    output logic [gs_dl_pkg::data_w-1:0]  reg_data
);

    gs_dl_pkg::region_e            region_d;
    logic [gs_dl_pkg::addr_w-1:0]  offset_d;
    logic                          keep;

    // Highest region first, so each compare only needs a lower bound
    always_comb begin
        if (cap_addr >= gs_dl_pkg::prom_end) begin
            region_d = gs_dl_pkg::reg_none;
        end else if (cap_addr >= gs_dl_pkg::prom_base) begin
            region_d = gs_dl_pkg::reg_prom;
        end else if (cap_addr >= gs_dl_pkg::obj_base) begin
            region_d = gs_dl_pkg::reg_obj;
        end else if (cap_addr >= gs_dl_pkg::scroll_base) begin
            region_d = gs_dl_pkg::reg_scroll;
        end else if (cap_addr >= gs_dl_pkg::map_base) begin
            region_d = gs_dl_pkg::reg_map;
        end else if (cap_addr >= gs_dl_pkg::char_base) begin
            region_d = gs_dl_pkg::reg_char;
        end else if (cap_addr >= gs_dl_pkg::sound_base) begin
            region_d = gs_dl_pkg::reg_sound;
        end else begin
            region_d = gs_dl_pkg::reg_main;
        end
    end

    assign offset_d = cap_addr - gs_dl_pkg::region_base(region_d);

    // Out of map bytes never become valid downstream
    assign keep = cap_valid && (region_d != gs_dl_pkg::reg_none);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_valid <= 1'b0;
        end else if (!stall) begin
            reg_valid <= keep;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && keep) begin
            reg_region <= region_d;
            reg_offset <= offset_d;
            reg_data   <= cap_data;
        end
    end

endmodule

//--- src/gs_dl_remap.sv
// Download remap stage
// Turns a region and offset into an SDRAM word write with lane mask,
// held until acknowledge, or into a one-cycle PROM write pulse

`timescale 1ns/100ps

module gs_dl_remap (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              reg_valid,
    input  gs_dl_pkg::region_e                reg_region,
    input  logic [gs_dl_pkg::addr_w-1:0]      reg_offset,
    input  logic [gs_dl_pkg::data_w-1:0]      reg_data,
    input  logic                              sdram_ack,
    output logic                              stall,
    output logic [gs_dl_pkg::addr_w-1:0]      prog_addr,
    output logic [gs_dl_pkg::data_w-1:0]      prog_data,
    output logic [gs_dl_pkg::mask_w-1:0]      prog_mask,
    output logic                              prog_we,
    output logic [gs_dl_pkg::prom_count-1:0]  prom_we
);

    logic                              accept;
    logic                              is_prom;
    logic                              lane_hi;
    logic [gs_dl_pkg::addr_w-1:0]      base;
    logic [gs_dl_pkg::addr_w-1:0]      byte_addr;
    logic [gs_dl_pkg::addr_w-1:0]      word_addr;
    logic [gs_dl_pkg::prom_idx_w-1:0]  prom_idx;

    // Next item waits while the current word is still unacknowledged
    assign stall   = prog_we && reg_valid;
    assign accept  = reg_valid && !prog_we;
    assign is_prom = (reg_region == gs_dl_pkg::reg_prom);

    always_comb begin
        base      = gs_dl_pkg::region_base(reg_region);
        byte_addr = base + reg_offset;
        case (reg_region)
            gs_dl_pkg::reg_scroll, gs_dl_pkg::reg_obj: begin
                // Two ROM halves interleaved as low and high lanes
                if (reg_offset < gs_dl_pkg::gfx_half) begin
                    lane_hi   = 1'b0;
                    word_addr = (base >> 1) + reg_offset;
                end else begin
                    lane_hi   = 1'b1;
                    word_addr = (base >> 1) + reg_offset - gs_dl_pkg::gfx_half;
                end
            end
            default: begin
                lane_hi   = byte_addr[0];
                word_addr = byte_addr >> 1;
            end
        endcase
    end

    assign prom_idx = gs_dl_pkg::prom_idx_w'(reg_offset / gs_dl_pkg::prom_size);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            prom_we <= '0;
            if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;
            end else if (accept && !is_prom) begin
                prog_we <= 1'b1;
            end
            // Spare PROM socket is not fitted on this board
            if (accept && is_prom && prom_idx != gs_dl_pkg::prom_spare) begin
                prom_we <= gs_dl_pkg::prom_count'(1) << prom_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            prog_data <= reg_data;
            if (is_prom) begin
                prog_addr <= gs_dl_pkg::addr_w'(reg_offset % gs_dl_pkg::prom_size);
                prog_mask <= 2'b11;
            end else begin
                prog_addr <= word_addr;
                prog_mask <= lane_hi ? 2'b01 : 2'b10;
            end
        end
    end

endmodule

//--- src/gs_download.sv
// ROM download top level
// Capture, region decode and remap stages in a chain, sharing one stall.
// Without stall an output appears three clock edges after the strobe

`timescale 1ns/100ps

module gs_download (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              downloading,
    input  logic                              ioctl_wr,
    input  logic [gs_dl_pkg::addr_w-1:0]      ioctl_addr,
    input  logic [gs_dl_pkg::data_w-1:0]      ioctl_dout,
    input  logic                              sdram_ack,
    output logic [gs_dl_pkg::addr_w-1:0]      prog_addr,
    output logic [gs_dl_pkg::data_w-1:0]      prog_data,
    output logic [gs_dl_pkg::mask_w-1:0]      prog_mask,
    output logic                              prog_we,
    output logic [gs_dl_pkg::prom_count-1:0]  prom_we
);

    logic                          stall;
    logic                          cap_valid;
    logic [gs_dl_pkg::addr_w-1:0]  cap_addr;
    logic [gs_dl_pkg::data_w-1:0]  cap_data;
    logic                          reg_valid;
    gs_dl_pkg::region_e            reg_region;
    logic [gs_dl_pkg::addr_w-1:0]  reg_offset;
    logic [gs_dl_pkg::data_w-1:0]  reg_data;

    gs_dl_capture gs_dl_capture_inst (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .stall       ( stall       ),
        .cap_valid   ( cap_valid   ),
        .cap_addr    ( cap_addr    ),
        .cap_data    ( cap_data    )
    );

    gs_dl_region gs_dl_region_inst (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cap_valid  ( cap_valid  ),
        .cap_addr   ( cap_addr   ),
        .cap_data   ( cap_data   ),
        .stall      ( stall      ),
        .reg_valid  ( reg_valid  ),
        .reg_region ( reg_region ),
        .reg_offset ( reg_offset ),
        .reg_data   ( reg_data   )
    );

    // Stall comes back from the last stage to both earlier ones
    gs_dl_remap gs_dl_remap_inst (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .reg_valid  ( reg_valid  ),
        .reg_region ( reg_region ),
        .reg_offset ( reg_offset ),
        .reg_data   ( reg_data   ),
        .sdram_ack  ( sdram_ack  ),
        .stall      ( stall      ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .prog_we    ( prog_we    ),
        .prom_we    ( prom_we    )
    );

endmodule
